/* common/revoke_pkg.sv */
/*
 * Revocation checker shared constants: heap and bitmap geometry,
 * capability metadata layout, Wishbone word map and sweep FSM states
 */
package revoke_pkg;

  // heap covered by the bitmap, one bit per 8-byte granule
  localparam logic [31:0] HEAP_BASE   = 32'h8000_0000;
  localparam int          TSMAP_WORDS = 64;
  localparam int          TSMAP_AW    = 6;

  // capability store
  localparam int CAPS   = 16;
  localparam int CAP_AW = 4;
  localparam int REG_AW = 5;

  // metadata word layout
  localparam int META_TAG      = 31;
  localparam int META_PERM_LSB = 26;
  localparam int META_EXP_LSB  = 21;

  // Wishbone word addresses
  localparam int                WB_AW         = 7;
  localparam logic [WB_AW-1:0] WB_TSMAP_BASE = 7'h00;
  localparam logic [WB_AW-1:0] WB_CAP_BASE   = 7'h40;
  localparam logic [WB_AW-1:0] WB_CTRL_ADDR  = 7'h60;

  // sweep FSM encoding
  localparam logic [1:0] SW_IDLE  = 2'd0;
  localparam logic [1:0] SW_ISSUE = 2'd1;
  localparam logic [1:0] SW_WAIT  = 2'd2;
  localparam logic [1:0] SW_STEP  = 2'd3;

endpackage

/* revoke/sweep_counter.sv */
/*
 * Sweep counters: current store entry index and number of
 * capabilities revoked by the running sweep
 */
module sweep_counter (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          rewind_i,
  input  logic                          step_i,
  input  logic                          clear_i,
  output logic [revoke_pkg::CAP_AW-1:0] index_o,
  output logic                          last_o,
  output logic [7:0]                    revoked_o
);

  assign last_o = (index_o == revoke_pkg::CAP_AW'(revoke_pkg::CAPS - 1));

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      index_o   <= '0;
      revoked_o <= '0;
    end else if (rewind_i) begin
      index_o   <= '0;
      revoked_o <= '0;
    end else begin
      if (step_i) begin
        index_o <= index_o + 1'b1;
      end
      if (clear_i) begin
        revoked_o <= revoked_o + 8'd1;
      end
    end
  end

endmodule

/* revoke/sweep_fsm.sv */
/*
 * Sweep FSM: walks the capability store one entry at a time,
 * yielding to pending CPU lookups
 */
module sweep_fsm (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic start_i,
  input  logic cpu_pending_i,
  input  logic last_i,
  input  logic clr_en_i,
  input  logic clr_tag_i,
  output logic busy_o,
  output logic rd_en_o,
  output logic step_o,
  output logic clear_o,
  output logic rewind_o
);

  logic [1:0] state_q;
  logic [1:0] state_d;

  always_comb begin
    state_d  = state_q;
    rd_en_o  = 1'b0;
    step_o   = 1'b0;
    clear_o  = 1'b0;
    rewind_o = 1'b0;
    case (state_q)
      revoke_pkg::SW_IDLE: begin
        if (start_i) begin
          rewind_o = 1'b1;
          state_d  = revoke_pkg::SW_ISSUE;
        end
      end
      revoke_pkg::SW_ISSUE: begin
        // keep the lookup input free for a CPU response
        if (!cpu_pending_i) begin
          rd_en_o = 1'b1;
          state_d = revoke_pkg::SW_WAIT;
        end
      end
      revoke_pkg::SW_WAIT: begin
        if (clr_en_i) begin
          clear_o = clr_tag_i;
          state_d = last_i ? revoke_pkg::SW_IDLE : revoke_pkg::SW_STEP;
        end
      end
      default: begin
        step_o  = 1'b1;
        state_d = revoke_pkg::SW_ISSUE;
      end
    endcase
  end

  assign busy_o = (state_q != revoke_pkg::SW_IDLE);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= revoke_pkg::SW_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

endmodule

/* revoke/revoke_lookup.sv */
/*
 * Revocation lookup: three-stage pipeline that checks a loaded or swept
 * capability against the revocation bitmap, shared by CPU and sweeper
 */
module revoke_lookup (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  logic                              rsv_en_i,
  input  logic [revoke_pkg::REG_AW-1:0]     rsv_addr_i,
  input  logic                              lsu_resp_valid_i,
  input  logic                              lsu_err_i,
  input  logic [31:0]                       lsu_meta_i,
  input  logic [31:0]                       lsu_addr_i,
  input  logic                              sweep_valid_i,
  input  logic [31:0]                       sweep_meta_i,
  input  logic [31:0]                       sweep_addr_i,
  input  logic [31:0]                       tsmap_rdata_i,
  output logic                              cpu_pending_o,
  output logic                              tsmap_cs_o,
  output logic [revoke_pkg::TSMAP_AW-1:0]   tsmap_addr_o,
  output logic                              rf_clr_en_o,
  output logic [revoke_pkg::REG_AW-1:0]     rf_clr_addr_o,
  output logic                              rf_clr_tag_o,
  output logic                              sweep_clr_en_o,
  output logic                              sweep_clr_tag_o
);

  logic                          armed_q;
  logic [revoke_pkg::REG_AW-1:0] rsv_addr_q;
  logic                          cpu_in;
  logic                          good_in;
  logic [2:0]                    cpu_v_q;
  logic [2:0]                    sweep_v_q;
  logic [1:0]                    good_q;
  logic [revoke_pkg::REG_AW-1:0] raddr_q [3];
  logic [31:0]                   meta_q;
  logic [31:0]                   addr_q;
  logic [4:0]                    exp;
  logic [4:0]                    perm;
  logic [31:0]                   base;
  logic [31:0]                   granule;
  logic                          sealed;
  logic                          range_ok;
  logic                          range_q;
  logic [4:0]                    bitpos_q;
  logic                          clr_q;

  // a response only counts as a CPU op while a reservation is armed
  assign cpu_in        = armed_q & lsu_resp_valid_i;
  assign good_in       = (cpu_in & ~lsu_err_i & lsu_meta_i[revoke_pkg::META_TAG]) |
                         (sweep_valid_i & sweep_meta_i[revoke_pkg::META_TAG]);
  assign cpu_pending_o = armed_q | rsv_en_i;

  // stage 1 decode of the registered capability
  assign exp      = meta_q[revoke_pkg::META_EXP_LSB +: 5];
  assign perm     = meta_q[revoke_pkg::META_PERM_LSB +: 5];
  assign base     = addr_q & (32'hFFFF_FFFF << exp);
  assign granule  = (base - revoke_pkg::HEAP_BASE) >> 3;
  assign sealed   = (perm[4:3] == 2'b00) && (perm[2:0] != 3'b000);
  assign range_ok = (base >= revoke_pkg::HEAP_BASE) &&
                    (granule[31:5] < revoke_pkg::TSMAP_WORDS) && !sealed;

  assign tsmap_cs_o   = (cpu_v_q[0] | sweep_v_q[0]) & good_q[0] & range_ok;
  assign tsmap_addr_o = granule[revoke_pkg::TSMAP_AW+4:5];

  assign rf_clr_en_o     = cpu_v_q[2];
  assign rf_clr_addr_o   = raddr_q[2];
  assign rf_clr_tag_o    = cpu_v_q[2] & clr_q;
  assign sweep_clr_en_o  = sweep_v_q[2];
  assign sweep_clr_tag_o = sweep_v_q[2] & clr_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      armed_q   <= 1'b0;
      cpu_v_q   <= '0;
      sweep_v_q <= '0;
      good_q    <= '0;
    end else begin
      if (rsv_en_i) begin
        armed_q <= 1'b1;
      end else if (lsu_resp_valid_i) begin
        armed_q <= 1'b0;
      end
      cpu_v_q   <= {cpu_v_q[1:0], cpu_in};
      sweep_v_q <= {sweep_v_q[1:0], sweep_valid_i};
      good_q    <= {good_q[0], good_in};
    end
  end

  always_ff @(posedge clk_i) begin
    if (rsv_en_i) begin
      rsv_addr_q <= rsv_addr_i;
    end
    // stage 0 capture, the two sources never collide
    if (cpu_in) begin
      meta_q <= lsu_meta_i;
      addr_q <= lsu_addr_i;
    end else if (sweep_valid_i) begin
      meta_q <= sweep_meta_i;
      addr_q <= sweep_addr_i;
    end
    raddr_q[0] <= rsv_addr_q;
    raddr_q[1] <= raddr_q[0];
    raddr_q[2] <= raddr_q[1];
    // stage 1
    bitpos_q <= granule[4:0];
    range_q  <= range_ok;
    // stage 2 picks the granule bit
    clr_q <= tsmap_rdata_i[bitpos_q] & good_q[1] & range_q;
  end

endmodule

/* hdl/tsmap_ram.sv */
/*
 * Revocation bitmap memory, one bit per heap granule, with a host
 * port and a lookup read port, both read through a register
 */
module tsmap_ram (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  logic                            host_we_i,
  input  logic                            host_re_i,
  input  logic [revoke_pkg::TSMAP_AW-1:0] host_addr_i,
  input  logic [31:0]                     host_wdata_i,
  input  logic                            lk_cs_i,
  input  logic [revoke_pkg::TSMAP_AW-1:0] lk_addr_i,
  output logic [31:0]                     host_rdata_o,
  output logic [31:0]                     lk_rdata_o
);

  logic [31:0] mem [revoke_pkg::TSMAP_WORDS];

  always_ff @(posedge clk_i) begin
    if (host_we_i) begin
      mem[host_addr_i] <= host_wdata_i;
    end
  end

  // read registers hold their word until the next access
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      host_rdata_o <= '0;
      lk_rdata_o   <= '0;
    end else begin
      if (host_re_i) begin
        host_rdata_o <= mem[host_addr_i];
      end
      if (lk_cs_i) begin
        lk_rdata_o <= mem[lk_addr_i];
      end
    end
  end

endmodule

/* hdl/cap_store.sv */
/*
 * Capability store: metadata and address word pairs walked by the
 * sweeper, with host access and tag clearing of revoked entries
 */
module cap_store (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          host_we_i,
  input  logic                          host_re_i,
  input  logic [revoke_pkg::CAP_AW:0]   host_addr_i,
  input  logic [31:0]                   host_wdata_i,
  input  logic                          rd_en_i,
  input  logic [revoke_pkg::CAP_AW-1:0] rd_index_i,
  input  logic                          clr_i,
  input  logic [revoke_pkg::CAP_AW-1:0] clr_index_i,
  output logic [31:0]                   host_rdata_o,
  output logic                          rd_valid_o,
  output logic [31:0]                   rd_meta_o,
  output logic [31:0]                   rd_addr_o
);

  logic [31:0]                   meta_mem [revoke_pkg::CAPS];
  logic [31:0]                   addr_mem [revoke_pkg::CAPS];
  logic [revoke_pkg::CAP_AW-1:0] host_idx;

  // even word is metadata, odd word is address
  assign host_idx = host_addr_i[revoke_pkg::CAP_AW:1];

  always_ff @(posedge clk_i) begin
    if (host_we_i && !host_addr_i[0]) begin
      meta_mem[host_idx] <= host_wdata_i;
    end
    if (host_we_i && host_addr_i[0]) begin
      addr_mem[host_idx] <= host_wdata_i;
    end
    if (clr_i) begin
      meta_mem[clr_index_i][revoke_pkg::META_TAG] <= 1'b0;
    end
    if (host_re_i) begin
      host_rdata_o <= host_addr_i[0] ? addr_mem[host_idx] : meta_mem[host_idx];
    end
    if (rd_en_i) begin
      rd_meta_o <= meta_mem[rd_index_i];
      rd_addr_o <= addr_mem[rd_index_i];
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_valid_o <= 1'b0;
    end else begin
      rd_valid_o <= rd_en_i;
    end
  end

endmodule

/* hdl/wb_regs.sv */
/*
 * Wishbone classic slave: decodes the word map onto bitmap, store and
 * control, acks every access on the cycle after the strobe
 */
module wb_regs (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  logic                            wb_cyc_i,
  input  logic                            wb_stb_i,
  input  logic                            wb_we_i,
  input  logic [revoke_pkg::WB_AW-1:0]    wb_adr_i,
  input  logic [31:0]                     wb_dat_i,
  input  logic                            busy_i,
  input  logic [7:0]                      revoked_i,
  input  logic [31:0]                     tsmap_rdata_i,
  input  logic [31:0]                     cap_rdata_i,
  output logic                            wb_ack_o,
  output logic [31:0]                     wb_dat_o,
  output logic                            tsmap_we_o,
  output logic                            tsmap_re_o,
  output logic                            cap_we_o,
  output logic                            cap_re_o,
  output logic [revoke_pkg::TSMAP_AW-1:0] mem_addr_o,
  output logic [31:0]                     mem_wdata_o,
  output logic                            start_o
);

  logic req;
  logic is_tsmap;
  logic is_cap;
  logic is_ctrl;

  // first cycle of an access, the ack cycle never starts a new one
  assign req = wb_cyc_i & wb_stb_i & ~wb_ack_o;

  assign is_tsmap = (wb_adr_i[6] == revoke_pkg::WB_TSMAP_BASE[6]);
  assign is_cap   = (wb_adr_i[6:5] == revoke_pkg::WB_CAP_BASE[6:5]);
  assign is_ctrl  = (wb_adr_i == revoke_pkg::WB_CTRL_ADDR);

  // memories sample on the same edge that raises ack
  assign tsmap_we_o  = req & wb_we_i & is_tsmap;
  assign tsmap_re_o  = req & ~wb_we_i & is_tsmap;
  assign cap_we_o    = req & wb_we_i & is_cap;
  assign cap_re_o    = req & ~wb_we_i & is_cap;
  assign mem_addr_o  = wb_adr_i[revoke_pkg::TSMAP_AW-1:0];
  assign mem_wdata_o = wb_dat_i;

  always_comb begin
    if (is_tsmap) begin
      wb_dat_o = tsmap_rdata_i;
    end else if (is_cap) begin
      wb_dat_o = cap_rdata_i;
    end else if (is_ctrl) begin
      wb_dat_o = {16'h0, revoked_i, 7'h0, busy_i};
    end else begin
      wb_dat_o = '0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wb_ack_o <= 1'b0;
      start_o  <= 1'b0;
    end else begin
      wb_ack_o <= req;
      // start only from idle, a write while busy is dropped
      start_o  <= req & wb_we_i & is_ctrl & wb_dat_i[0] & ~busy_i;
    end
  end

endmodule

/* hdl/revoke_top.sv */
/*
 * Capability revocation checker top level: lookup pipeline, sweeper,
 * bitmap, capability store and Wishbone register block
 */
module revoke_top (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          wb_cyc_i,
  input  logic                          wb_stb_i,
  input  logic                          wb_we_i,
  input  logic [revoke_pkg::WB_AW-1:0]  wb_adr_i,
  input  logic [31:0]                   wb_dat_i,
  output logic                          wb_ack_o,
  output logic [31:0]                   wb_dat_o,
  input  logic                          rsv_en_i,
  input  logic [revoke_pkg::REG_AW-1:0] rsv_addr_i,
  input  logic                          lsu_resp_valid_i,
  input  logic                          lsu_err_i,
  input  logic [31:0]                   lsu_meta_i,
  input  logic [31:0]                   lsu_addr_i,
  output logic                          rf_clr_en_o,
  output logic [revoke_pkg::REG_AW-1:0] rf_clr_addr_o,
  output logic                          rf_clr_tag_o
);

  logic                            cpu_pending;
  logic                            tsmap_cs;
  logic [revoke_pkg::TSMAP_AW-1:0] tsmap_addr;
  logic [31:0]                     tsmap_rdata;
  logic                            sweep_valid;
  logic [31:0]                     sweep_meta;
  logic [31:0]                     sweep_addr;
  logic                            sweep_clr_en;
  logic                            sweep_clr_tag;
  logic                            busy;
  logic                            rd_en;
  logic                            step;
  logic                            clear;
  logic                            rewind;
  logic [revoke_pkg::CAP_AW-1:0]   index;
  logic                            last;
  logic [7:0]                      revoked;
  logic                            tsmap_we;
  logic                            tsmap_re;
  logic                            cap_we;
  logic                            cap_re;
  logic [revoke_pkg::TSMAP_AW-1:0] mem_addr;
  logic [31:0]                     mem_wdata;
  logic                            start;
  logic [31:0]                     tsmap_host_rdata;
  logic [31:0]                     cap_host_rdata;

  revoke_lookup u_lookup (
    .clk_i, .rst_ni, .rsv_en_i, .rsv_addr_i, .lsu_resp_valid_i, .lsu_err_i,
    .lsu_meta_i, .lsu_addr_i,
    .sweep_valid_i(sweep_valid), .sweep_meta_i(sweep_meta), .sweep_addr_i(sweep_addr),
    .tsmap_rdata_i(tsmap_rdata), .cpu_pending_o(cpu_pending),
    .tsmap_cs_o(tsmap_cs), .tsmap_addr_o(tsmap_addr),
    .rf_clr_en_o, .rf_clr_addr_o, .rf_clr_tag_o,
    .sweep_clr_en_o(sweep_clr_en), .sweep_clr_tag_o(sweep_clr_tag)
  );

  sweep_fsm u_fsm (
    .clk_i, .rst_ni, .start_i(start), .cpu_pending_i(cpu_pending), .last_i(last),
    .clr_en_i(sweep_clr_en), .clr_tag_i(sweep_clr_tag), .busy_o(busy),
    .rd_en_o(rd_en), .step_o(step), .clear_o(clear), .rewind_o(rewind)
  );

  sweep_counter u_counter (
    .clk_i, .rst_ni, .rewind_i(rewind), .step_i(step), .clear_i(clear),
    .index_o(index), .last_o(last), .revoked_o(revoked)
  );

  tsmap_ram u_tsmap (
    .clk_i, .rst_ni, .host_we_i(tsmap_we), .host_re_i(tsmap_re),
    .host_addr_i(mem_addr), .host_wdata_i(mem_wdata),
    .lk_cs_i(tsmap_cs), .lk_addr_i(tsmap_addr),
    .host_rdata_o(tsmap_host_rdata), .lk_rdata_o(tsmap_rdata)
  );

  cap_store u_caps (
    .clk_i, .rst_ni, .host_we_i(cap_we), .host_re_i(cap_re),
    .host_addr_i(mem_addr[revoke_pkg::CAP_AW:0]), .host_wdata_i(mem_wdata),
    .rd_en_i(rd_en), .rd_index_i(index), .clr_i(clear), .clr_index_i(index),
    .host_rdata_o(cap_host_rdata), .rd_valid_o(sweep_valid),
    .rd_meta_o(sweep_meta), .rd_addr_o(sweep_addr)
  );

  wb_regs u_regs (
    .clk_i, .rst_ni, .wb_cyc_i, .wb_stb_i, .wb_we_i, .wb_adr_i, .wb_dat_i,
    .busy_i(busy), .revoked_i(revoked),
    .tsmap_rdata_i(tsmap_host_rdata), .cap_rdata_i(cap_host_rdata),
    .wb_ack_o, .wb_dat_o, .tsmap_we_o(tsmap_we), .tsmap_re_o(tsmap_re),
    .cap_we_o(cap_we), .cap_re_o(cap_re), .mem_addr_o(mem_addr),
    .mem_wdata_o(mem_wdata), .start_o(start)
  );

endmodule

/* tb/revoke_props.sv */
/*
 * Lookup and bus timing properties, bound into the lookup pipeline
 * and the Wishbone register block
 */
module revoke_props (
  input logic clk_i,
  input logic rst_ni,
  input logic resp_i,
  input logic sweep_i,
  input logic clr_en_i,
  input logic clr_tag_i,
  input logic ack_i
);
  timeunit 1ns;
  timeprecision 100ps;

  int fail_count = 0;

  // cpu response leaves stage 2 three cycles later
  resp_to_clear: assert property (@(posedge clk_i) disable iff (!rst_ni)
    resp_i |-> ##3 clr_en_i)
    else begin
      fail_count++;
      $error("no clear enable 3 cycles after a CPU response");
    end

  ack_single: assert property (@(posedge clk_i) disable iff (!rst_ni)
    ack_i |=> !ack_i)
    else begin
      fail_count++;
      $error("ack held for 2 cycles");
    end

  tag_needs_en: assert property (@(posedge clk_i) disable iff (!rst_ni)
    clr_tag_i |-> clr_en_i)
    else begin
      fail_count++;
      $error("tag clear without clear enable");
    end

  // sweeper must yield the lookup input to the CPU
  no_collision: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(resp_i && sweep_i))
    else begin
      fail_count++;
      $error("CPU and sweep inputs valid in the same cycle");
    end

endmodule

bind revoke_lookup revoke_props u_lookup_props (
  .clk_i, .rst_ni, .resp_i(cpu_in), .sweep_i(sweep_valid_i),
  .clr_en_i(rf_clr_en_o), .clr_tag_i(rf_clr_tag_o), .ack_i(1'b0)
);

bind wb_regs revoke_props u_bus_props (
  .clk_i, .rst_ni, .resp_i(1'b0), .sweep_i(1'b0),
  .clr_en_i(1'b0), .clr_tag_i(1'b0), .ack_i(wb_ack_o)
);

/* tb/revoke_tb.sv */
/*
 * Revocation checker testbench: host access, CPU lookups against a
 * reference model, pipelined bursts and a full store sweep
 */
module revoke_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int BURSTS    = 60;
  localparam int NUM_OPS   = BURSTS * 4 + 26 +
                             3 * (revoke_pkg::TSMAP_WORDS + 2 * revoke_pkg::CAPS) + 40;
  localparam int WD_CYCLES = NUM_OPS * 20 + revoke_pkg::CAPS * 40 + 200;

  logic        clk;
  logic        rst_n;
  logic        wb_cyc;
  logic        wb_stb;
  logic        wb_we;
  logic [6:0]  wb_adr;
  logic [31:0] wb_dat_w;
  logic [31:0] wb_dat_r;
  logic        wb_ack;
  logic        rsv_en;
  logic [4:0]  rsv_addr;
  logic        lsu_valid;
  logic        lsu_err;
  logic [31:0] lsu_meta;
  logic [31:0] lsu_addr;
  logic        rf_clr_en;
  logic [4:0]  rf_clr_addr;
  logic        rf_clr_tag;

  logic [31:0] seed = 32'h1895877a;
  int          cycle = 0;
  int          errors = 0;
  int          checks = 0;
  // host view of bitmap and store
  logic [31:0] tsmap_m [revoke_pkg::TSMAP_WORDS];
  logic [31:0] meta_m [revoke_pkg::CAPS];
  logic [31:0] addr_m [revoke_pkg::CAPS];
  // ops of the next burst, and expected clears in flight
  logic [31:0] op_meta [$];
  logic [31:0] op_addr [$];
  logic        op_err [$];
  logic [4:0]  op_reg [$];
  int          exp_due [$];
  logic [4:0]  exp_reg [$];
  logic        exp_tag [$];

  revoke_top dut (
    .clk_i(clk), .rst_ni(rst_n), .wb_cyc_i(wb_cyc), .wb_stb_i(wb_stb), .wb_we_i(wb_we),
    .wb_adr_i(wb_adr), .wb_dat_i(wb_dat_w), .wb_ack_o(wb_ack), .wb_dat_o(wb_dat_r),
    .rsv_en_i(rsv_en), .rsv_addr_i(rsv_addr), .lsu_resp_valid_i(lsu_valid),
    .lsu_err_i(lsu_err), .lsu_meta_i(lsu_meta), .lsu_addr_i(lsu_addr),
    .rf_clr_en_o(rf_clr_en), .rf_clr_addr_o(rf_clr_addr), .rf_clr_tag_o(rf_clr_tag)
  );

  always #50 clk = ~clk;

  always @(posedge clk) cycle <= cycle + 1;

  function automatic logic [31:0] next_rand();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  // revoked when tagged, unsealed, no error and the base granule bit is set
  function automatic logic revoked_ref(input logic [31:0] meta, input logic [31:0] addr,
                                       input logic err);
    logic [4:0]  exp;
    logic [4:0]  perm;
    logic [31:0] base;
    logic [31:0] gran;
    exp  = meta[revoke_pkg::META_EXP_LSB +: 5];
    perm = meta[revoke_pkg::META_PERM_LSB +: 5];
    base = addr & ~((32'd1 << exp) - 32'd1);
    if (!meta[revoke_pkg::META_TAG] || err || base < revoke_pkg::HEAP_BASE) begin
      return 1'b0;
    end
    if (perm[4:3] == 2'b00 && perm[2:0] != 3'b000) begin
      return 1'b0;
    end
    gran = (base - revoke_pkg::HEAP_BASE) / 8;
    if (gran / 32 >= revoke_pkg::TSMAP_WORDS) begin
      return 1'b0;
    end
    return tsmap_m[gran / 32][gran % 32];
  endfunction

  // about half the capabilities land in the mapped heap
  task automatic rand_cap(output logic [31:0] meta, output logic [31:0] addr);
    logic [31:0] r;
    r = next_rand();
    meta = next_rand();
    meta[revoke_pkg::META_TAG] = r[0] | r[1];
    addr = next_rand();
    if (r[2]) begin
      meta[revoke_pkg::META_EXP_LSB +: 5] = {2'b00, r[5:3]};
      addr = revoke_pkg::HEAP_BASE + {18'h0, r[19:6]};
    end
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #10;
  endtask

  task automatic bus_cycle(input logic we, input logic [6:0] adr, input logic [31:0] wdata,
                           output logic [31:0] rdata);
    next_cycle();
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_adr   = adr;
    wb_dat_w = wdata;
    do begin
      next_cycle();
    end while (!wb_ack);
    rdata  = wb_dat_r;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
  endtask

  task automatic bus_write(input logic [6:0] adr, input logic [31:0] data);
    logic [31:0] unused;
    bus_cycle(1'b1, adr, data, unused);
  endtask

  task automatic bus_read(input logic [6:0] adr, output logic [31:0] data);
    bus_cycle(1'b0, adr, 32'h0, data);
  endtask

  task automatic check_eq(input string what, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("ERROR %0t ns: %s expected %h got %h", $time, what, exp, act);
    end
  endtask

  task automatic queue_op(input logic [4:0] rd, input logic [31:0] meta,
                          input logic [31:0] addr, input logic err);
    op_reg.push_back(rd);
    op_meta.push_back(meta);
    op_addr.push_back(addr);
    op_err.push_back(err);
  endtask

  // reservation of op i shares a cycle with the response of op i-1
  task automatic cpu_burst();
    int n;
    n = op_meta.size();
    for (int i = 0; i <= n; i++) begin
      next_cycle();
      rsv_en    = (i < n);
      lsu_valid = (i > 0);
      if (i < n) begin
        rsv_addr = op_reg[i];
      end
      if (i > 0) begin
        lsu_meta = op_meta[i-1];
        lsu_addr = op_addr[i-1];
        lsu_err  = op_err[i-1];
        exp_due.push_back(cycle + 3);
        exp_reg.push_back(op_reg[i-1]);
        exp_tag.push_back(revoked_ref(op_meta[i-1], op_addr[i-1], op_err[i-1]));
      end
    end
    next_cycle();
    lsu_valid = 1'b0;
    op_reg.delete();
    op_meta.delete();
    op_addr.delete();
    op_err.delete();
  endtask

  // compare clear outputs away from the clock edge
  always @(negedge clk) begin
    if (exp_due.size() > 0 && exp_due[0] == cycle) begin
      checks++;
      if (rf_clr_en !== 1'b1 || rf_clr_addr !== exp_reg[0] || rf_clr_tag !== exp_tag[0]) begin
        errors++;
        $display("ERROR %0t ns: clear expected en 1 r%0d tag %b, got en %b r%0d tag %b",
                 $time, exp_reg[0], exp_tag[0], rf_clr_en, rf_clr_addr, rf_clr_tag);
      end
      void'(exp_due.pop_front());
      void'(exp_reg.pop_front());
      void'(exp_tag.pop_front());
    end else if (rst_n && rf_clr_en !== 1'b0) begin
      errors++;
      $display("ERROR %0t ns: clear enable expected 0 got %b", $time, rf_clr_en);
    end
  end

  initial begin
    #(WD_CYCLES * 100);
    $display("timeout: run did not finish within %0d cycles", WD_CYCLES);
    $display("Test failed");
    $finish;
  end

  initial begin
    logic [31:0] rd;
    logic [31:0] meta;
    logic [31:0] addr;
    logic [31:0] r;
    int          len;
    int          cleared;
    int          afails;
    clk       = 1'b0;
    rst_n     = 1'b0;
    wb_cyc    = 1'b0;
    wb_stb    = 1'b0;
    wb_we     = 1'b0;
    wb_adr    = '0;
    wb_dat_w  = '0;
    rsv_en    = 1'b0;
    rsv_addr  = '0;
    lsu_valid = 1'b0;
    lsu_err   = 1'b0;
    lsu_meta  = '0;
    lsu_addr  = '0;
    repeat (5) @(posedge clk);
    #10;
    rst_n = 1'b1;

    check_eq("ack after reset", 32'(0), 32'(wb_ack));
    check_eq("clear tag after reset", 32'(0), 32'(rf_clr_tag));
    bus_read(revoke_pkg::WB_CTRL_ADDR, rd);
    check_eq("status after reset", 32'h0, rd);

    // host fill, which also seeds the lookups
    for (int i = 0; i < revoke_pkg::TSMAP_WORDS; i++) begin
      tsmap_m[i] = next_rand();
      bus_write(revoke_pkg::WB_TSMAP_BASE + 7'(i), tsmap_m[i]);
    end
    for (int i = 0; i < revoke_pkg::CAPS; i++) begin
      rand_cap(meta_m[i], addr_m[i]);
      bus_write(revoke_pkg::WB_CAP_BASE + 7'(2 * i), meta_m[i]);
      bus_write(revoke_pkg::WB_CAP_BASE + 7'(2 * i + 1), addr_m[i]);
    end
    for (int i = 0; i < revoke_pkg::TSMAP_WORDS; i++) begin
      bus_read(revoke_pkg::WB_TSMAP_BASE + 7'(i), rd);
      check_eq("bitmap readback", tsmap_m[i], rd);
    end
    for (int i = 0; i < revoke_pkg::CAPS; i++) begin
      bus_read(revoke_pkg::WB_CAP_BASE + 7'(2 * i), rd);
      check_eq("store meta readback", meta_m[i], rd);
      bus_read(revoke_pkg::WB_CAP_BASE + 7'(2 * i + 1), rd);
      check_eq("store addr readback", addr_m[i], rd);
    end

    // random bursts of 1 to 4 lookups
    for (int b = 0; b < BURSTS; b++) begin
      len = 1 + int'(next_rand() % 4);
      for (int k = 0; k < len; k++) begin
        rand_cap(meta, addr);
        r = next_rand();
        queue_op(r[4:0], meta, addr, r[8:5] == 4'h0);
      end
      cpu_burst();
    end

    // word 0 fully revoked so only the first op may clear
    tsmap_m[0] = 32'hFFFF_FFFF;
    bus_write(revoke_pkg::WB_TSMAP_BASE, tsmap_m[0]);
    queue_op(5'd1, 32'hFC00_0000, revoke_pkg::HEAP_BASE + 32'h10, 1'b0);
    queue_op(5'd2, 32'h8400_0000, revoke_pkg::HEAP_BASE + 32'h10, 1'b0);
    queue_op(5'd3, 32'h7C00_0000, revoke_pkg::HEAP_BASE + 32'h10, 1'b0);
    queue_op(5'd4, 32'hFC00_0000, revoke_pkg::HEAP_BASE + 32'h10, 1'b1);
    queue_op(5'd5, 32'hFC00_0000, 32'h7FFF_FFF8, 1'b0);
    queue_op(5'd6, 32'hFC00_0000, revoke_pkg::HEAP_BASE + 32'h4000, 1'b0);
    cpu_burst();

    // long back-to-back burst
    for (int k = 0; k < 12; k++) begin
      rand_cap(meta, addr);
      queue_op(5'(k + 10), meta, addr, 1'b0);
    end
    cpu_burst();

    cleared = 0;
    for (int i = 0; i < revoke_pkg::CAPS; i++) begin
      if (revoked_ref(meta_m[i], addr_m[i], 1'b0)) begin
        cleared++;
        meta_m[i][revoke_pkg::META_TAG] = 1'b0;
      end
    end
    for (int k = 0; k < 8; k++) begin
      rand_cap(meta, addr);
      queue_op(5'(k + 22), meta, addr, 1'b0);
    end
    bus_write(revoke_pkg::WB_CTRL_ADDR, 32'h1);
    // cpu lookups run alongside the sweep, which has to yield to them
    fork
      cpu_burst();
      do begin
        bus_read(revoke_pkg::WB_CTRL_ADDR, rd);
      end while (rd[0]);
    join
    check_eq("revoked count", 32'(cleared), 32'(rd[15:8]));
    for (int i = 0; i < revoke_pkg::CAPS; i++) begin
      bus_read(revoke_pkg::WB_CAP_BASE + 7'(2 * i), rd);
      check_eq("meta after sweep", meta_m[i], rd);
    end

    next_cycle();
    afails = dut.u_lookup.u_lookup_props.fail_count + dut.u_regs.u_bus_props.fail_count;
    $display("checks: %0d, errors: %0d, assertion failures: %0d", checks, errors, afails);
    if (errors == 0 && afails == 0 && exp_due.size() == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

/* list.f */
common/revoke_pkg.sv
revoke/sweep_counter.sv
revoke/sweep_fsm.sv
revoke/revoke_lookup.sv
hdl/tsmap_ram.sv
hdl/cap_store.sv
hdl/wb_regs.sv
hdl/revoke_top.sv
tb/revoke_props.sv
tb/revoke_tb.sv
